// ==== Bender.yml ====
package:
  name: rcc_vsw

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rcc_bdcr_pkg.sv
      - rtl/lse_pkg.sv
      - rtl/rcc_bdcr_access.sv
      - rtl/rcc_vsw_reg.sv
      - rtl/lse_ctrl_fsm.sv
      - rtl/lse_timer.sv
      - rtl/rcc_vsw_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/rcc_vsw_chk.sv
      - tests/rcc_vsw_tb.sv

// ==== rcc_vsw_top.f ====
+incdir+rtl
rtl/rcc_bdcr_pkg.sv
rtl/lse_pkg.sv
rtl/rcc_bdcr_access.sv
rtl/rcc_vsw_reg.sv
rtl/lse_ctrl_fsm.sv
rtl/lse_timer.sv
rtl/rcc_vsw_top.sv
tests/rcc_vsw_chk.sv
tests/rcc_vsw_tb.sv

// ==== rtl/lse_ctrl_fsm.sv ====
// lse supervision state machine
// off, startup count, ready with clock security watchdog, failure
// drives the shared timer and reports rdy and the css_fail pulse

`timescale 1ns/1ps
`default_nettype none

module lse_ctrl_fsm (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire lse_pkg::lse_ctl_t  ctl,
  input  wire                     rdy_hit,
  input  wire                     wdog_hit,
  input  wire                     tick,
  output logic                    cnt_clr,
  output logic                    cnt_mode,
  output lse_pkg::lse_stat_t      stat
);

  lse_pkg::lse_state_e state;
  lse_pkg::lse_state_e state_next;
  logic                css_fail_q;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      lse_pkg::LSE_OFF: begin
        if (ctl.on) begin
          state_next = lse_pkg::LSE_START;
        end
      end
      lse_pkg::LSE_START: begin
        // bypass has no crystal to wait for
        if (!ctl.on) begin
          state_next = lse_pkg::LSE_OFF;
        end else if (ctl.byp || rdy_hit) begin
          state_next = lse_pkg::LSE_RDY;
        end
      end
      lse_pkg::LSE_RDY: begin
        if (!ctl.on) begin
          state_next = lse_pkg::LSE_OFF;
        end else if (ctl.csson && wdog_hit) begin
          state_next = lse_pkg::LSE_FAIL;
        end
      end
      lse_pkg::LSE_FAIL: begin
        // only software turning the oscillator off leaves here
        if (!ctl.on) begin
          state_next = lse_pkg::LSE_OFF;
        end
      end
      default: begin
        state_next = lse_pkg::LSE_OFF;
      end
    endcase
  end

  // --------------------
  // state and css pulse
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= lse_pkg::LSE_OFF;
      css_fail_q <= 1'b0;
    end else begin
      state      <= state_next;
      // high for the first cycle in fail only
      css_fail_q <= (state == lse_pkg::LSE_RDY) && (state_next == lse_pkg::LSE_FAIL);
    end
  end

  // timer control
  // fresh count on every state entry, and per tick while ready
  assign cnt_clr  = (state_next != state) || ((state == lse_pkg::LSE_RDY) && tick);
  // 1 counts clk cycles for the watchdog, 0 counts lse ticks
  assign cnt_mode = (state == lse_pkg::LSE_RDY);

  assign stat = '{rdy: (state == lse_pkg::LSE_RDY), css_fail: css_fail_q};

endmodule

`default_nettype wire

// ==== rtl/lse_pkg.sv ====
// lse oscillator control types
// fsm state enum, timer count, control and status structs

`default_nettype none

package lse_pkg;

  // oscillator supervision states
  typedef enum logic [1:0] {
    LSE_OFF   = 2'd0,
    LSE_START = 2'd1,
    LSE_RDY   = 2'd2,
    LSE_FAIL  = 2'd3
  } lse_state_e;

  // shared tick / cycle counter, wide enough for both limits
  typedef logic [4:0] lse_cnt_t;

  // register fields that steer the fsm
  typedef struct packed {
    logic on;
    logic byp;
    logic csson;
  } lse_ctl_t;

  // fsm status back to register and read port
  typedef struct packed {
    logic rdy;
    logic css_fail;
  } lse_stat_t;

endpackage

`default_nettype wire

// ==== rtl/lse_timer.sv ====
// shared counter for lse startup ticks and watchdog cycles
// saturating count with hit flags against the configured limits

`timescale 1ns/1ps
`default_nettype none

`include "rcc_vsw_config.svh"

module lse_timer (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  cnt_clr,
  input  wire  cnt_mode,
  input  wire  tick,
  output logic rdy_hit,
  output logic wdog_hit
);

  // last count value before each limit is reached
  localparam lse_pkg::lse_cnt_t rdy_last  = lse_pkg::lse_cnt_t'(`RCC_LSE_RDY_TICKS - 1);
  localparam lse_pkg::lse_cnt_t wdog_last = lse_pkg::lse_cnt_t'(`RCC_LSE_CSS_LIMIT - 1);

  lse_pkg::lse_cnt_t cnt;
  logic              step;

  // cycle mode advances every clk, tick mode only on a tick
  assign step = cnt_mode | tick;

  // --------------------
  // counter
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (cnt_clr) begin
      cnt <= '0;
    end else if (step && (cnt != '1)) begin
      // hold at all ones, no wrap back to zero
      cnt <= cnt + 5'd1;
    end
  end

  // --------------------
  // hits
  // --------------------
  // the tick that completes the startup count
  assign rdy_hit  = !cnt_mode && tick && (cnt == rdy_last);
  // limit-th quiet cycle, a tick here restarts the count instead
  assign wdog_hit = cnt_mode && !tick && (cnt >= wdog_last);

endmodule

`default_nettype wire

// ==== rtl/rcc_bdcr_access.sv ====
// write and read port of the backup domain control register
// write side turns pulse and strobes into byte enables and typed next values
// read side builds the word from the bit map and returns it one cycle later

`timescale 1ns/1ps
`default_nettype none

module rcc_bdcr_access (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         bus_wr,
  input  wire                         bus_rd,
  input  wire [31:0]                  bus_wdata,
  input  wire [3:0]                   bus_wstrb,
  input  wire rcc_bdcr_pkg::bdcr_t    cur,
  input  wire                         lsecssd,
  input  wire lse_pkg::lse_stat_t     stat,
  output rcc_bdcr_pkg::bdcr_wr_t      wr,
  output logic [31:0]                 bus_rdata,
  output logic                        bus_rvalid
);

  logic [31:0] rd_word;

  // --------------------
  // write side
  // --------------------
  // byte 3 holds no field, so strobe bit 3 has nothing to enable
  always_comb begin
    wr.be           = {3{bus_wr}} & bus_wstrb[2:0];
    // byte 0, lse controls
    wr.nxt.lseon    = bus_wdata[0];
    wr.nxt.lsebyp   = bus_wdata[2];
    wr.nxt.lsedrv   = bus_wdata[4:3];
    wr.nxt.lsecsson = bus_wdata[5];
    // byte 1, rtc source and enable
    wr.nxt.rtcsel   = bus_wdata[9:8];
    wr.nxt.rtcen    = bus_wdata[15];
    // byte 2, backup domain reset
    wr.nxt.bdrst    = bus_wdata[16];
  end

  // --------------------
  // read side
  // --------------------
  // stored fields plus the two status bits the register does not own
  always_comb begin
    rd_word        = '0;
    rd_word[0]     = cur.lseon;
    rd_word[1]     = stat.rdy;
    rd_word[2]     = cur.lsebyp;
    rd_word[4:3]   = cur.lsedrv;
    rd_word[5]     = cur.lsecsson;
    rd_word[6]     = lsecssd;
    rd_word[9:8]   = cur.rtcsel;
    rd_word[15]    = cur.rtcen;
    rd_word[16]    = cur.bdrst;
  end

  // sample at the bus_rd edge, valid for one cycle after
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus_rvalid <= 1'b0;
      bus_rdata  <= '0;
    end else begin
      bus_rvalid <= bus_rd;
      // data holds between reads
      if (bus_rd) begin
        bus_rdata <= rd_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rcc_bdcr_pkg.sv ====
// backup domain control register layout
// field types, writable field struct and the byte write struct

`default_nettype none

package rcc_bdcr_pkg;

  // --------------------
  // bit map of the 32-bit word
  // --------------------
  // | bit(s) | field    | access           |
  // |--------|----------|------------------|
  // | 0      | lseon    | rw               |
  // | 1      | lserdy   | ro, from the fsm |
  // | 2      | lsebyp   | rw               |
  // | 4:3    | lsedrv   | rw               |
  // | 5      | lsecsson | write 1 to set   |
  // | 6      | lsecssd  | ro, sticky       |
  // | 9:8    | rtcsel   | write once       |
  // | 15     | rtcen    | rw               |
  // | 16     | bdrst    | rw               |
  // all other bits read zero
  // byte 0 holds lse fields, byte 1 rtc fields, byte 2 bdrst

  // lse drive strength level
  typedef logic [1:0] drv_t;

  // rtc clock source, zero means no clock selected
  typedef logic [1:0] rtcsel_t;

  // writable fields only, msb first as in the word
  typedef struct packed {
    logic    bdrst;
    logic    rtcen;
    rtcsel_t rtcsel;
    logic    lsecsson;
    drv_t    lsedrv;
    logic    lsebyp;
    logic    lseon;
  } bdcr_t;

  // one write: byte enables for bytes 0..2 plus the next field values
  typedef struct packed {
    logic [2:0] be;
    bdcr_t      nxt;
  } bdcr_wr_t;

endpackage

`default_nettype wire

// ==== rtl/rcc_vsw_config.svh ====
// tunable counts for the backup-domain clock block
// lse startup tick count, clock security watchdog limit
// reset value of the backup domain control register

`ifndef RCC_VSW_CONFIG_SVH
`define RCC_VSW_CONFIG_SVH

// --------------------
// lse startup
// --------------------
// lse_tick pulses seen in startup before the oscillator counts as ready
`define RCC_LSE_RDY_TICKS 8

// --------------------
// clock security
// --------------------
// clk cycles in ready with no lse_tick that flag a failed oscillator
`define RCC_LSE_CSS_LIMIT 16

// --------------------
// register reset
// --------------------
// full 32-bit word, sliced per field by the register block
`define RCC_BDCR_RST 32'h0000_0000

`endif

// ==== rtl/rcc_vsw_reg.sv ====
// backup domain control register field storage
// rw fields, write-once rtcsel, write-1-to-set lsecsson
// sticky clock security flag and backup domain soft reset

`timescale 1ns/1ps
`default_nettype none

`include "rcc_vsw_config.svh"

module rcc_vsw_reg (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire rcc_bdcr_pkg::bdcr_wr_t   wr,
  input  wire lse_pkg::lse_stat_t       stat,
  output rcc_bdcr_pkg::bdcr_t           cur,
  output logic                          lsecssd,
  output lse_pkg::lse_ctl_t             ctl
);

  // --------------------
  // reset values
  // --------------------
  localparam logic [31:0] rst_word = `RCC_BDCR_RST;

  // fields pulled out of the reset word by the bit map
  localparam rcc_bdcr_pkg::bdcr_t rst_val = '{
    bdrst:    rst_word[16],
    rtcen:    rst_word[15],
    rtcsel:   rst_word[9:8],
    lsecsson: rst_word[5],
    lsedrv:   rst_word[4:3],
    lsebyp:   rst_word[2],
    lseon:    rst_word[0]
  };

  // a nonzero reset source already counts as a committed choice
  localparam logic rst_lock = (rst_word[9:8] != 2'b00);

  // set once rtcsel got a nonzero value
  logic rtcsel_lock;
  // bdrst as it stands after this edge
  logic hold;

  // a write of bdrst=1 clears the rest in the same cycle
  assign hold = wr.be[2] ? wr.nxt.bdrst : cur.bdrst;

  // --------------------
  // field storage
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cur         <= rst_val;
      rtcsel_lock <= rst_lock;
      lsecssd     <= rst_word[6];
    end else if (hold) begin
      // domain held in reset, only bdrst itself stays set
      cur         <= rst_val;
      cur.bdrst   <= 1'b1;
      rtcsel_lock <= rst_lock;
      lsecssd     <= rst_word[6];
    end else begin
      if (wr.be[2]) begin
        cur.bdrst <= wr.nxt.bdrst;
      end

      // byte 0, plain rw lse fields
      if (wr.be[0]) begin
        cur.lseon    <= wr.nxt.lseon;
        cur.lsebyp   <= wr.nxt.lsebyp;
        cur.lsedrv   <= wr.nxt.lsedrv;
        // writes of 0 do nothing once set
        cur.lsecsson <= cur.lsecsson | wr.nxt.lsecsson;
      end

      // byte 1, rtcen rw, rtcsel only until locked
      if (wr.be[1]) begin
        cur.rtcen <= wr.nxt.rtcen;
        if (!rtcsel_lock) begin
          cur.rtcsel  <= wr.nxt.rtcsel;
          rtcsel_lock <= (wr.nxt.rtcsel != 2'b00);
        end
      end

      // failed lse: csson off, rtc source free again, flag sticks
      // last so it wins over a write in the same cycle
      if (stat.css_fail) begin
        cur.lsecsson <= 1'b0;
        rtcsel_lock  <= 1'b0;
        lsecssd      <= 1'b1;
      end
    end
  end

  // controls for the oscillator fsm
  assign ctl = '{on: cur.lseon, byp: cur.lsebyp, csson: cur.lsecsson};

endmodule

`default_nettype wire

// ==== rtl/rcc_vsw_top.sv ====
// backup-domain corner of the reset and clock controller
// bus port, bdcr storage, lse state machine and shared timer

`timescale 1ns/1ps
`default_nettype none

module rcc_vsw_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   bus_wr,
  input  wire                   bus_rd,
  input  wire [31:0]            bus_wdata,
  input  wire [3:0]             bus_wstrb,
  input  wire                   lse_tick,
  output logic [31:0]           bus_rdata,
  output logic                  bus_rvalid,
  output logic                  lse_en,
  output logic                  lse_byp,
  output rcc_bdcr_pkg::drv_t    lse_drv,
  output logic                  rtc_en,
  output rcc_bdcr_pkg::rtcsel_t rtc_sel,
  output logic                  bdrst,
  output logic                  lse_rdy,
  output logic                  css_fail
);

  // --------------------
  // internal nets
  // --------------------
  rcc_bdcr_pkg::bdcr_wr_t wr;
  rcc_bdcr_pkg::bdcr_t    cur;
  logic                   lsecssd;
  lse_pkg::lse_ctl_t      ctl;
  lse_pkg::lse_stat_t     stat;
  logic                   cnt_clr;
  logic                   cnt_mode;
  logic                   rdy_hit;
  logic                   wdog_hit;

  rcc_bdcr_access u_access (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_wr     (bus_wr),
    .bus_rd     (bus_rd),
    .bus_wdata  (bus_wdata),
    .bus_wstrb  (bus_wstrb),
    .cur        (cur),
    .lsecssd    (lsecssd),
    .stat       (stat),
    .wr         (wr),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid)
  );

  rcc_vsw_reg u_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .stat    (stat),
    .cur     (cur),
    .lsecssd (lsecssd),
    .ctl     (ctl)
  );

  lse_ctrl_fsm u_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctl      (ctl),
    .rdy_hit  (rdy_hit),
    .wdog_hit (wdog_hit),
    .tick     (lse_tick),
    .cnt_clr  (cnt_clr),
    .cnt_mode (cnt_mode),
    .stat     (stat)
  );

  lse_timer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cnt_clr  (cnt_clr),
    .cnt_mode (cnt_mode),
    .tick     (lse_tick),
    .rdy_hit  (rdy_hit),
    .wdog_hit (wdog_hit)
  );

  // --------------------
  // pin outputs
  // --------------------
  // register fields straight out to the oscillator and rtc
  assign lse_en   = cur.lseon;
  assign lse_byp  = cur.lsebyp;
  assign lse_drv  = cur.lsedrv;
  assign rtc_en   = cur.rtcen;
  assign rtc_sel  = cur.rtcsel;
  assign bdrst    = cur.bdrst;
  // status from the fsm
  assign lse_rdy  = stat.rdy;
  assign css_fail = stat.css_fail;

endmodule

`default_nettype wire

// ==== tests/rcc_vsw_chk.sv ====
// concurrent checks on the backup-domain clock block
// read latency, css pulse width, ready gating, rtcsel lock
// bound into the top level below the module

`timescale 1ns/1ps
`default_nettype none

module rcc_vsw_chk (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         bus_rd,
  input wire                         bus_rvalid,
  input wire                         lse_en,
  input wire                         lse_rdy,
  input wire                         css_fail,
  input wire rcc_bdcr_pkg::rtcsel_t  rtc_sel,
  input wire                         rtc_lock,
  input wire                         hold
);

  // failed assertions, read back by the testbench
  int fail_cnt = 0;

  // --------------------
  // read port
  // --------------------
  rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid == $past(bus_rd))
    else begin
      fail_cnt++;
      $error("bus_rvalid does not follow bus_rd by exactly one cycle");
    end

  // --------------------
  // lse supervision
  // --------------------
  css_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    css_fail |=> !css_fail)
    else begin
      fail_cnt++;
      $error("css_fail high for more than one cycle");
    end

  // ready only with the oscillator enabled
  rdy_gate: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(lse_rdy) |-> lse_en)
    else begin
      fail_cnt++;
      $error("lse_rdy rose while lse_en was low");
    end

  // locked source moves only on css failure or domain reset
  sel_lock: assert property (@(posedge clk) disable iff (!rst_n)
    (rtc_lock && !css_fail && !hold) |=> $stable(rtc_sel))
    else begin
      fail_cnt++;
      $error("rtc_sel changed while locked");
    end

endmodule

bind rcc_vsw_top rcc_vsw_chk chk0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .bus_rd     (bus_rd),
  .bus_rvalid (bus_rvalid),
  .lse_en     (lse_en),
  .lse_rdy    (lse_rdy),
  .css_fail   (css_fail),
  .rtc_sel    (rtc_sel),
  .rtc_lock   (u_reg.rtcsel_lock),
  .hold       (u_reg.hold)
);

`default_nettype wire

// ==== tests/rcc_vsw_tb.sv ====
// testbench for the backup-domain clock block
// random bdcr writes against a shadow model, write-once and w1s fields
// lse startup, bypass, css failure and backup domain reset

`timescale 1ns/1ps
`default_nettype none

`include "rcc_vsw_config.svh"

module rcc_vsw_tb;

  localparam int n_rand  = 40;
  // writes plus reads of the random phase and the directed steps
  localparam int n_steps = 2 * n_rand + 30;
  localparam int wdog_cycles = 40 * n_steps + 3 * `RCC_LSE_RDY_TICKS + 4 * `RCC_LSE_CSS_LIMIT;

  logic        clk;
  logic        rst_n;
  logic        bus_wr;
  logic        bus_rd;
  logic [31:0] bus_wdata;
  logic [3:0]  bus_wstrb;
  logic        lse_tick;
  logic [31:0] bus_rdata;
  logic        bus_rvalid;
  logic        lse_en;
  logic        lse_byp;
  logic [1:0]  lse_drv;
  logic        rtc_en;
  logic [1:0]  rtc_sel;
  logic        bdrst;
  logic        lse_rdy;
  logic        css_fail;

  // shadow register, writable bits only
  logic [31:0] m_word;
  logic        m_lock;
  logic        m_cssd;
  logic        m_rdy;
  int          errors;
  int          checks;
  logic [31:0] seed;
  logic [31:0] d;
  int          n;
  int          n_ticks;
  int          i;

  rcc_vsw_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hard stop if the run stalls
  initial begin
    #(wdog_cycles * 10);
    $display("timeout, the tests did not finish in %0d cycles", wdog_cycles);
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // --------------------
  // reference model
  // --------------------
  function automatic void model_write(input logic [31:0] data, input logic [3:0] strb);
    logic hold;
    hold = strb[2] ? data[16] : m_word[16];
    if (hold) begin
      // whole domain back to reset, bdrst stays
      m_word = 32'h0001_0000;
      m_lock = 1'b0;
      m_cssd = 1'b0;
    end else begin
      if (strb[2]) begin
        m_word[16] = data[16];
      end
      if (strb[0]) begin
        m_word[0]   = data[0];
        m_word[4:2] = data[4:2];
        // write 1 to set
        m_word[5]   = m_word[5] | data[5];
      end
      if (strb[1]) begin
        m_word[15] = data[15];
        if (!m_lock) begin
          m_word[9:8] = data[9:8];
          m_lock      = (data[9:8] != 2'b00);
        end
      end
    end
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic write_reg(input logic [31:0] data, input logic [3:0] strb);
    @(negedge clk);
    bus_wr    = 1'b1;
    bus_wdata = data;
    bus_wstrb = strb;
    @(negedge clk);
    bus_wr = 1'b0;
    model_write(data, strb);
  endtask

  // read back, then compare word and pins with the model
  task automatic read_check();
    logic [31:0] exp;
    int          wait_n;
    exp    = m_word | {25'd0, m_cssd, 4'd0, m_rdy, 1'b0};
    wait_n = 0;
    @(negedge clk);
    bus_rd = 1'b1;
    @(negedge clk);
    bus_rd = 1'b0;
    while (!bus_rvalid && wait_n < 4) begin
      @(negedge clk);
      wait_n++;
    end
    if (bus_rvalid) begin
      check_val("bus_rdata", bus_rdata, exp);
    end else begin
      errors++;
      $display("read got no bus_rvalid response");
    end
    check_val("lse_en", lse_en, m_word[0]);
    check_val("lse_byp", lse_byp, m_word[2]);
    check_val("lse_drv", lse_drv, m_word[4:3]);
    check_val("rtc_en", rtc_en, m_word[15]);
    check_val("rtc_sel", rtc_sel, m_word[9:8]);
    check_val("bdrst", bdrst, m_word[16]);
    check_val("lse_rdy", lse_rdy, m_rdy);
    check_val("css_fail", css_fail, 32'd0);
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    rst_n     = 1'b0;
    bus_wr    = 1'b0;
    bus_rd    = 1'b0;
    bus_wdata = '0;
    bus_wstrb = '0;
    lse_tick  = 1'b0;
    m_word    = '0;
    m_lock    = 1'b0;
    m_cssd    = 1'b0;
    m_rdy     = 1'b0;
    errors    = 0;
    checks    = 0;
    seed      = 32'he6a6;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    read_check();

    // random fields, lseon and bdrst kept low so the fsm stays off
    for (i = 0; i < n_rand; i++) begin
      seed = lcg_next(seed);
      d    = seed & 32'hfffe_fffe;
      seed = lcg_next(seed);
      write_reg(d, seed[31:28]);
      read_check();
    end

    // clean slate, then rtcsel lock and lsecsson set-only
    write_reg(32'h0001_0000, 4'h4);
    write_reg(32'h0000_0000, 4'h4);
    read_check();
    write_reg(32'h0000_0200, 4'h2);
    write_reg(32'h0000_0100, 4'h2);
    write_reg(32'h0000_0020, 4'h1);
    write_reg(32'h0000_0000, 4'h1);
    read_check();

    // crystal startup, a tick every third cycle
    write_reg(32'h0000_0021, 4'h1);
    @(negedge clk);
    n_ticks = 0;
    for (i = 0; i < 3 * `RCC_LSE_RDY_TICKS + 6; i++) begin
      lse_tick = (i % 3 == 0);
      @(negedge clk);
      if (lse_tick) begin
        n_ticks++;
      end
      m_rdy = (n_ticks >= `RCC_LSE_RDY_TICKS);
      check_val("lse_rdy", lse_rdy, m_rdy);
    end

    // one last tick, then silence until the watchdog fires
    lse_tick = 1'b1;
    @(negedge clk);
    lse_tick = 1'b0;
    n = 0;
    while (!css_fail && n < 4 * `RCC_LSE_CSS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!css_fail) begin
      errors++;
      $display("css_fail never pulsed after the ticks stopped");
    end
    check_val("css_fail delay", n, `RCC_LSE_CSS_LIMIT);
    m_word[5] = 1'b0;
    m_lock    = 1'b0;
    m_cssd    = 1'b1;
    m_rdy     = 1'b0;
    @(negedge clk);
    read_check();
    write_reg(32'h0000_0300, 4'h2);
    read_check();

    // bypass is ready right after startup entry
    write_reg(32'h0000_0000, 4'h1);
    write_reg(32'h0000_0005, 4'h1);
    @(negedge clk);
    check_val("lse_rdy", lse_rdy, m_rdy);
    @(negedge clk);
    m_rdy = 1'b1;
    check_val("lse_rdy", lse_rdy, m_rdy);
    read_check();
    write_reg(32'h0000_0004, 4'h1);
    @(negedge clk);
    m_rdy = 1'b0;
    check_val("lse_rdy", lse_rdy, m_rdy);

    // backup domain reset holds every field
    write_reg(32'h0001_0000, 4'h4);
    read_check();
    write_reg(32'h0000_8321, 4'h3);
    read_check();
    write_reg(32'h0000_0000, 4'h4);
    read_check();

    @(negedge clk);
    $display("checks %0d, check errors %0d, assertion errors %0d",
             checks, errors, dut0.chk0.fail_cnt);
    if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
